//--- vlog.f
logic/cpuIsaPkg.sv
logic/cpuCtrlPkg.sv
logic/branchCondition.sv
logic/insDecoder.sv
logic/ctrlSequencer.sv
logic/cpuController.sv
dv/cpuController_assert.sv
dv/cpuControllerTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -sv --timescale 1ns/100ps \
    --top-module cpuControllerTb -f vlog.f -o simCpuController

output=$(./obj_dir/simCpuController)
echo "$output"

if grep -qx "TESTS PASSED" <<< "$output"; then
    exit 0
fi
exit 1

//--- dv/cpuControllerTb.sv
module cpuControllerTb
    import cpuIsaPkg::*;
    import cpuCtrlPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // 4 ns clock period
    localparam int halfPeriod = 2;
    localparam int resetCycles = 5;
    // Watchdog budget and per-handshake wait limit
    localparam int cyclesPerEntry = 20;
    localparam int handshakeLimit = 16;

    // One table row: instruction, flags, hand-written expected word
    typedef struct packed {
        insT      ins;
        psrT      psr;
        ctrlWordT want;
    } vecT;

    logic     Clock;
    logic     Reset;
    logic     insValid;
    logic     insReady;
    insT      ins;
    psrT      psr;
    logic     ctrlValid;
    logic     ctrlReady;
    ctrlWordT ctrl;

    vecT    vecs[$];
    integer seed = 32'he891_8379;
    int     errors = 0;
    int     checks = 0;
    int     words = 0;
    logic   tableLoaded = 1'b0;

    cpuController UUT (
        .Clock     (Clock),
        .Reset     (Reset),
        .insValid  (insValid),
        .insReady  (insReady),
        .ins       (ins),
        .psr       (psr),
        .ctrlValid (ctrlValid),
        .ctrlReady (ctrlReady),
        .ctrl      (ctrl)
    );

    initial
    begin
        Clock = 1'b0;
        forever #halfPeriod Clock = ~Clock;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    // Assemble an expected control word field by field
    function automatic ctrlWordT expWord(input int op, input int ext, input int wr,
        input int rin, input int ra, input int rb, input int imm, input aluSelT sel,
        input int mw, input int step);
        ctrlWordT w;
        w.aluOp     = fieldWidth'(op);
        w.aluExt    = fieldWidth'(ext);
        w.regWrite  = 1'(wr);
        w.regIn     = fieldWidth'(rin);
        w.regA      = fieldWidth'(ra);
        w.regB      = fieldWidth'(rb);
        w.immediate = insWidth'(imm);
        w.aluSel    = sel;
        w.memWrite  = 1'(mw);
        w.pcStep    = pcStepWidth'(step);
        return w;
    endfunction

    task automatic addVec(input insT i, input psrT p, input ctrlWordT w);
        vecT v;
        v.ins  = i;
        v.psr  = p;
        v.want = w;
        vecs.push_back(v);
    endtask

    task automatic logMismatch(input string msg);
        errors++;
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    task automatic logProblem(input string msg);
        errors++;
        $display("Handshake problem at %0t: %s", $time, msg);
    endtask

    // Advance to the next falling edge, new random ready there
    task automatic nextCycle();
        int r;
        @(negedge Clock);
        r = $random(seed);
        ctrlReady = r[0];
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////////////////////////

    task automatic loadTable();
        // Register ALU, CMP, load and store
        addVec(16'h0256, 5'b00000, expWord(0, 2, 1, 6, 5, 6, 0, selRegister, 0, 1));
        addVec(16'h09A1, 5'b11111, expWord(0, 9, 1, 1, 'hA, 1, 0, selRegister, 0, 1));
        addVec(16'h3B47, 5'b01001, expWord(3, 'hB, 0, 0, 4, 7, 0, selRegister, 0, 1));
        addVec(16'h4082, 5'b00000, expWord(0, 13, 1, 2, 0, 8, 0, selMemory, 0, 1));
        addVec(16'h413C, 5'b00101, expWord(0, 13, 0, 0, 'hC, 3, 0, selRegister, 1, 1));
        // Sign-extended, negative and positive bytes
        addVec(16'h5F03, 5'b00000, expWord(5, 'hF, 1, 3, 0, 3, 'hFFF0, selImmediate, 0, 1));
        addVec(16'h5254, 5'b00000, expWord(5, 2, 1, 4, 0, 4, 'h0025, selImmediate, 0, 1));
        addVec(16'h9801, 5'b00000, expWord(9, 8, 1, 1, 0, 1, 'hFF80, selImmediate, 0, 1));
        addVec(16'h97F2, 5'b00000, expWord(9, 7, 1, 2, 0, 2, 'h007F, selImmediate, 0, 1));
        // Zero-extend, upper byte, ones over the top
        addVec(16'h6C35, 5'b00000, expWord(6, 'hC, 1, 5, 0, 5, 'h00C3, selImmediate, 0, 1));
        addVec(16'h89A6, 5'b01000, expWord(8, 9, 1, 6, 0, 6, 'h009A, selImmediate, 0, 1));
        addVec(16'h7AB7, 5'b00000, expWord(7, 'hA, 1, 7, 0, 7, 'hAB00, selImmediate, 0, 1));
        addVec(16'hB128, 5'b00000, expWord(11, 1, 0, 0, 2, 8, 'hFF12, selImmediate, 0, 1));
        // BGE, zero or carry
        addVec(16'h1000, 5'b01000, expWord(0, 0, 0, 0, 0, 0, 0, selRegister, 0, 1));
        addVec(16'h1000, 5'b00001, expWord(0, 0, 0, 0, 0, 0, 0, selRegister, 0, 1));
        addVec(16'h1000, 5'b00100, expWord(0, 0, 0, 0, 0, 0, 0, selRegister, 0, 2));
        // BHG, zero or low
        addVec(16'h1100, 5'b00100, expWord(0, 0, 0, 0, 0, 0, 0, selRegister, 0, 1));
        addVec(16'h1100, 5'b00001, expWord(0, 0, 0, 0, 0, 0, 0, selRegister, 0, 2));
        // BEQ, register bits ignored
        addVec(16'h12FF, 5'b01000, expWord(0, 0, 0, 0, 0, 0, 0, selRegister, 0, 1));
        addVec(16'h1200, 5'b10101, expWord(0, 0, 0, 0, 0, 0, 0, selRegister, 0, 2));
        // BLT, neither zero nor carry
        addVec(16'h1300, 5'b00100, expWord(0, 0, 0, 0, 0, 0, 0, selRegister, 0, 1));
        addVec(16'h13A5, 5'b00001, expWord(0, 0, 0, 0, 0, 0, 0, selRegister, 0, 2));
        // BLS, not low
        addVec(16'h1400, 5'b00001, expWord(0, 0, 0, 0, 0, 0, 0, selRegister, 0, 1));
        addVec(16'h1400, 5'b00100, expWord(0, 0, 0, 0, 0, 0, 0, selRegister, 0, 2));
        // Undefined encodings fall back to idle
        addVec(16'h2345, 5'b11111, expWord(0, 0, 0, 0, 0, 0, 0, selImmediate, 0, 1));
        addVec(16'h1700, 5'b00100, expWord(0, 0, 0, 0, 0, 0, 0, selImmediate, 0, 1));
        addVec(16'h4211, 5'b00000, expWord(0, 0, 0, 0, 0, 0, 0, selImmediate, 0, 1));
        addVec(16'hFFFF, 5'b11111, expWord(0, 0, 0, 0, 0, 0, 0, selImmediate, 0, 1));
    endtask

    //////////////////////////////////////////////////////////////////////
    // One instruction through both handshakes
    //////////////////////////////////////////////////////////////////////

    task automatic runEntry(input int idx);
        vecT v;
        int  waited;
        v = vecs[idx];
        insValid = 1'b1;
        ins      = v.ins;
        psr      = v.psr;
        waited   = 0;
        while (!insReady && waited < handshakeLimit)
        begin
            nextCycle();
            waited++;
        end
        if (!insReady)
        begin
            logProblem($sformatf("entry %0d was never accepted", idx));
            insValid = 1'b0;
            return;
        end
        // Input transfer on the coming rising edge
        nextCycle();
        insValid = 1'b0;
        ins      = '0;
        psr      = '0;
        checks++;
        if (!ctrlValid || insReady)
            logProblem($sformatf("entry %0d gave no output one cycle after fetch", idx));
        // Word must sit still while the consumer stalls
        waited = 0;
        while (ctrlValid && !ctrlReady && waited < handshakeLimit)
        begin
            checks++;
            if (ctrl !== v.want)
                logMismatch($sformatf("entry %0d stalled word %h, expected %h",
                    idx, ctrl, v.want));
            nextCycle();
            waited++;
        end
        if (!ctrlValid || !ctrlReady)
        begin
            logProblem($sformatf("entry %0d output was not transferred", idx));
            return;
        end
        checks++;
        if (ctrl !== v.want)
            logMismatch($sformatf("entry %0d word %h, expected %h", idx, ctrl, v.want));
        words++;
        // Output transfer on the coming edge, then back to fetch
        nextCycle();
        checks++;
        if (!insReady || ctrlValid)
            logProblem($sformatf("entry %0d did not return to fetch", idx));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        int i;
        Reset     = 1'b0;
        insValid  = 1'b0;
        ins       = '0;
        psr       = '0;
        ctrlReady = 1'b0;
        loadTable();
        tableLoaded = 1'b1;
        repeat (resetCycles) @(negedge Clock);
        Reset = 1'b1;
        nextCycle();
        // Fetch state and idle word out of reset
        checks++;
        if (!insReady || ctrlValid)
            logProblem("controller not in fetch after reset");
        if (ctrl !== idleWord)
            logMismatch($sformatf("word %h after reset, expected idle", ctrl));
        for (i = 0; i < vecs.size(); i++)
            runEntry(i);
        $display("Entries %0d, words %0d, checks %0d, errors %0d",
            vecs.size(), words, checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    // Budget grows with the table
    initial
    begin
        wait (tableLoaded);
        repeat (vecs.size() * cyclesPerEntry + resetCycles) @(posedge Clock);
        $display("Watchdog expired at %0t, the table run never finished", $time);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- dv/cpuController_assert.sv
module cpuControllerAssert
    import cpuCtrlPkg::*;
(
    input logic     Clock,
    input logic     Reset,
    input logic     insValid,
    input logic     insReady,
    input logic     ctrlValid,
    input logic     ctrlReady,
    input ctrlWordT ctrl
);

    timeunit 1ns;
    timeprecision 100ps;

    //////////////////////////////////////////////////////////////////////
    // Handshake rules
    //////////////////////////////////////////////////////////////////////

    // Stalled output keeps its word and its valid
    aHoldUnderStall: assert property (@(posedge Clock) disable iff (!Reset)
        ctrlValid && !ctrlReady |=> ctrlValid && $stable(ctrl))
        else $error("Output word or valid changed while stalled");

    // Accepted instruction moves to execute and blocks the next fetch
    aOneInFlight: assert property (@(posedge Clock) disable iff (!Reset)
        insValid && insReady |=> ctrlValid && !insReady)
        else $error("Accepted instruction did not leave fetch for execute");

    // First cycle out of reset is a fetch
    aIdleAfterReset: assert property (@(posedge Clock) $rose(Reset) |-> !ctrlValid)
        else $error("ctrlValid high right after reset release");

endmodule

bind cpuController cpuControllerAssert uAssert (
    .Clock     (Clock),
    .Reset     (Reset),
    .insValid  (insValid),
    .insReady  (insReady),
    .ctrlValid (ctrlValid),
    .ctrlReady (ctrlReady),
    .ctrl      (ctrl)
);

//--- logic/cpuController.sv
module cpuController
    import cpuIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  logic     Clock,
    input  logic     Reset,
    input  logic     insValid,
    output logic     insReady,
    input  insT      ins,
    input  psrT      psr,
    output logic     ctrlValid,
    input  logic     ctrlReady,
    output ctrlWordT ctrl
);

    //////////////////////////////////////////////////////////////////////
    // Internal connections
    //////////////////////////////////////////////////////////////////////

    insT                    heldIns;
    psrT                    heldPsr;
    ctrlWordT               decoded;
    logic [pcStepWidth-1:0] pcStep;

    // Handshakes and capture registers
    ctrlSequencer uSequencer (
        .Clock     (Clock),
        .Reset     (Reset),
        .insValid  (insValid),
        .insReady  (insReady),
        .ins       (ins),
        .psr       (psr),
        .ctrlValid (ctrlValid),
        .ctrlReady (ctrlReady),
        .heldIns   (heldIns),
        .heldPsr   (heldPsr),
        .decoded   (decoded),
        .ctrl      (ctrl)
    );

    // Field routing and immediate forming
    insDecoder uDecoder (
        .ins     (heldIns),
        .pcStep  (pcStep),
        .decoded (decoded)
    );

    // Skip resolution from the captured flags
    branchCondition uBranch (
        .ins    (heldIns),
        .psr    (heldPsr),
        .pcStep (pcStep)
    );

endmodule

//--- logic/ctrlSequencer.sv
module ctrlSequencer
    import cpuIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  logic     Clock,
    input  logic     Reset,
    // Fetch side
    input  logic     insValid,
    output logic     insReady,
    input  insT      ins,
    input  psrT      psr,
    // Execute side
    output logic     ctrlValid,
    input  logic     ctrlReady,
    // Captured instruction to the decoder
    output insT      heldIns,
    output psrT      heldPsr,
    input  ctrlWordT decoded,
    output ctrlWordT ctrl
);

    seqStateT state;
    seqStateT nextState;

    logic insFire;
    logic ctrlFire;

    assign insReady  = (state == stFetch);
    assign ctrlValid = (state == stExecute);
    assign insFire   = insValid & insReady;
    assign ctrlFire  = ctrlValid & ctrlReady;

    //////////////////////////////////////////////////////////////////////
    // Fetch/execute state machine
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        nextState = state;
        case (state)
            stFetch:
                if (insFire)
                    nextState = stExecute;
            stExecute:
                // Stay here under back-pressure
                if (ctrlFire)
                    nextState = stFetch;
            default:
                nextState = stFetch;
        endcase
    end

    always_ff @(posedge Clock or negedge Reset)
    begin
        if (!Reset)
            state <= stFetch;
        else
            state <= nextState;
    end

    // Instruction and flags captured on the input transfer
    always_ff @(posedge Clock)
    begin
        if (insFire)
        begin
            heldIns <= ins;
            heldPsr <= psr;
        end
    end

    // Decoded word only while executing, otherwise idle
    assign ctrl = (state == stExecute) ? decoded : idleWord;

endmodule

//--- logic/insDecoder.sv
module insDecoder
    import cpuIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  insT                    ins,
    input  logic [pcStepWidth-1:0] pcStep,
    output ctrlWordT               decoded
);

    //////////////////////////////////////////////////////////////////////
    // Instruction fields
    //////////////////////////////////////////////////////////////////////

    logic [fieldWidth-1:0] opBits;
    logic [fieldWidth-1:0] extBits;
    logic [fieldWidth-1:0] regHi;
    logic [fieldWidth-1:0] regLo;
    // 8-bit immediate sits in bits 11..4
    logic [insWidth/2-1:0] immByte;

    assign opBits  = ins[insWidth-1 -: fieldWidth];
    assign extBits = ins[insWidth-fieldWidth-1 -: fieldWidth];
    assign regHi   = ins[2*fieldWidth-1 -: fieldWidth];
    assign regLo   = ins[fieldWidth-1:0];
    assign immByte = ins[insWidth-fieldWidth-1 -: insWidth/2];

    // Four immediate forms
    logic [insWidth-1:0] immSigned;
    logic [insWidth-1:0] immZero;
    logic [insWidth-1:0] immUpper;
    logic [insWidth-1:0] immOnes;

    assign immSigned = {{(insWidth/2){immByte[insWidth/2-1]}}, immByte};
    assign immZero   = {{(insWidth/2){1'b0}}, immByte};
    assign immUpper  = {immByte, {(insWidth/2){1'b0}}};
    // CMPI compares against a byte over an all-ones upper half
    assign immOnes   = {{(insWidth/2){1'b1}}, immByte};

    //////////////////////////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        // Anything not matched below stays idle
        decoded = idleWord;
        case (opcodeT'(opBits))
            opAluReg, opCmp:
            begin
                decoded.aluOp    = opBits;
                decoded.aluExt   = extBits;
                decoded.regA     = regHi;
                decoded.regB     = regLo;
                decoded.aluSel   = selRegister;
                // CMP only updates flags
                decoded.regWrite = (opcodeT'(opBits) == opAluReg);
                decoded.regIn    = (opcodeT'(opBits) == opAluReg) ? regLo : '0;
            end
            opAddi, opSubi, opAddui, opMovi, opMoviu:
            begin
                decoded.aluOp    = opBits;
                decoded.aluExt   = extBits;
                decoded.regWrite = 1'b1;
                decoded.regIn    = regLo;
                decoded.regB     = regLo;
                decoded.aluSel   = selImmediate;
                case (opcodeT'(opBits))
                    opAddi, opSubi:
                        decoded.immediate = immSigned;
                    opMoviu:
                        decoded.immediate = immUpper;
                    default:
                        decoded.immediate = immZero;
                endcase
            end
            opCmpi:
            begin
                decoded.aluOp     = opBits;
                decoded.aluExt    = extBits;
                decoded.regA      = regHi;
                decoded.regB      = regLo;
                decoded.immediate = immOnes;
                decoded.aluSel    = selImmediate;
            end
            opMem:
            begin
                case (memExtT'(extBits))
                    memLoad:
                    begin
                        // Memory data passes the ALU as a move
                        decoded.aluExt   = aluMoveExt;
                        decoded.regWrite = 1'b1;
                        decoded.regIn    = regLo;
                        decoded.regB     = regHi;
                        decoded.aluSel   = selMemory;
                    end
                    memStore:
                    begin
                        // Address from regB, data from regA
                        decoded.aluExt   = aluMoveExt;
                        decoded.regA     = regLo;
                        decoded.regB     = regHi;
                        decoded.aluSel   = selRegister;
                        decoded.memWrite = 1'b1;
                    end
                    default:
                        decoded = idleWord;
                endcase
            end
            opBranch:
            begin
                // Only the step differs from idle
                case (branchT'(extBits))
                    brGe, brHg, brEq, brLt, brLs:
                        decoded.aluSel = selRegister;
                    default:
                        decoded = idleWord;
                endcase
            end
            default:
                decoded = idleWord;
        endcase
        // Step always comes from the branch unit
        decoded.pcStep = pcStep;
    end

endmodule

//--- logic/branchCondition.sv
module branchCondition
    import cpuIsaPkg::*;
(
    input  insT                    ins,
    input  psrT                    psr,
    output logic [pcStepWidth-1:0] pcStep
);

    logic [fieldWidth-1:0] opBits;
    logic [fieldWidth-1:0] extBits;
    logic                  zero;
    logic                  carry;
    logic                  low;
    // High means no skip
    logic                  condHolds;

    assign opBits  = ins[insWidth-1 -: fieldWidth];
    assign extBits = ins[insWidth-fieldWidth-1 -: fieldWidth];
    assign zero    = psr[flagZero];
    assign carry   = psr[flagCarry];
    assign low     = psr[flagLow];

    //////////////////////////////////////////////////////////////////////
    // Skip-branch conditions
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        condHolds = 1'b1;
        if (opcodeT'(opBits) == opBranch)
        begin
            case (branchT'(extBits))
                brGe:    condHolds = zero | carry;
                brHg:    condHolds = zero | low;
                brEq:    condHolds = zero;
                brLt:    condHolds = ~zero & ~carry;
                brLs:    condHolds = ~low;
                // Unknown code behaves like a no-op
                default: condHolds = 1'b1;
            endcase
        end
    end

    // Failed condition skips the next word
    assign pcStep = condHolds ? pcStepWidth'(1) : pcStepWidth'(2);

endmodule

//--- logic/cpuCtrlPkg.sv
package cpuCtrlPkg;

    import cpuIsaPkg::*;

    //////////////////////////////////////////////////////////////////////
    // Sequencer
    //////////////////////////////////////////////////////////////////////

    // Fetch waits on the input handshake, execute on the output one
    typedef enum logic {
        stFetch,
        stExecute
    } seqStateT;

    //////////////////////////////////////////////////////////////////////
    // Control word
    //////////////////////////////////////////////////////////////////////

    // Source of the second ALU operand
    typedef enum logic [1:0] {
        selImmediate = 2'd0,
        selRegister  = 2'd1,
        selMemory    = 2'd2
    } aluSelT;

    // One decoded instruction, as seen by the datapath
    typedef struct packed {
        logic [fieldWidth-1:0]  aluOp;
        logic [fieldWidth-1:0]  aluExt;
        logic                   regWrite;
        // Write-back register
        logic [fieldWidth-1:0]  regIn;
        // Read ports
        logic [fieldWidth-1:0]  regA;
        logic [fieldWidth-1:0]  regB;
        logic [insWidth-1:0]    immediate;
        aluSelT                 aluSel;
        logic                   memWrite;
        // Added to the PC after execute
        logic [pcStepWidth-1:0] pcStep;
    } ctrlWordT;

    // No write, no memory access, no step
    localparam ctrlWordT idleWord = '0;

endpackage

//--- logic/cpuIsaPkg.sv
package cpuIsaPkg;

    //////////////////////////////////////////////////////////////////////
    // Word and field sizes
    //////////////////////////////////////////////////////////////////////

    // Instruction and datapath width
    localparam int insWidth = 16;
    // Opcode, extension and register fields
    localparam int fieldWidth = 4;
    // Program-counter step carried in the control word
    localparam int pcStepWidth = 8;
    // Status flags from the PSR
    localparam int psrWidth = 5;

    // Flag positions read by the controller
    localparam int flagCarry = 0;
    localparam int flagLow = 2;
    localparam int flagZero = 3;

    //////////////////////////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////////////////////////

    // Major opcode, bits 15..12
    typedef enum logic [fieldWidth-1:0] {
        opAluReg = 4'd0,
        opBranch = 4'd1,
        opCmp    = 4'd3,
        opMem    = 4'd4,
        opAddi   = 4'd5,
        opAddui  = 4'd6,
        opMoviu  = 4'd7,
        opMovi   = 4'd8,
        opSubi   = 4'd9,
        opCmpi   = 4'd11
    } opcodeT;

    // Skip-branch condition in the extension field
    typedef enum logic [fieldWidth-1:0] {
        brGe = 4'd0,
        brHg = 4'd1,
        brEq = 4'd2,
        brLt = 4'd3,
        brLs = 4'd4
    } branchT;

    // Memory access kind in the extension field
    typedef enum logic [fieldWidth-1:0] {
        memLoad  = 4'd0,
        memStore = 4'd1
    } memExtT;

    // ALU move, used by load and store to pass data through
    localparam logic [fieldWidth-1:0] aluMoveExt = 4'd13;

    typedef logic [psrWidth-1:0] psrT;
    typedef logic [insWidth-1:0] insT;

endpackage
